/* dsp_pkg.sv */
package dsp_pkg;

  // widths of the measurement chain

  // raw adc word, two's complement
  typedef logic signed [13:0] sample_t;

  // halved |a| - |b|, the halving keeps it in 14 bits
  typedef logic signed [13:0] amp_t;

  typedef logic [10:0] index_t;   // position inside a frame
  typedef logic [29:0] energy_t;  // sum of three squares, unsigned
  typedef logic [14:0] root_t;    // floor sqrt of energy_t

  // largest frame the index type can address
  parameter int max_frame_len = 2048;

  // both adc channels, sampled on the same strobe
  typedef struct packed {
    sample_t chan_a;
    sample_t chan_b;
  } sample_pair_t;

  // frame maximum with its neighbours
  typedef struct packed {
    amp_t   prev;   // zero when index is 0
    amp_t   peak;
    amp_t   next;   // zero at the last frame position
    index_t index;
  } peak_t;

endpackage

/* link_pkg.sv */
package link_pkg;

  // serial report link

  typedef logic [7:0] byte_t;  // one uart data byte

  // 8n1 transmitter states
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } tx_state_t;

  // root hi/lo then index hi/lo
  parameter int report_bytes = 4;

endpackage

/* decimator.sv */
module decimator #(
  parameter int decim_rate = 7
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dsp_pkg::sample_pair_t sample_in,
  input  logic                  sample_strobe,
  output dsp_pkg::sample_pair_t pair,
  output logic                  pair_valid
);

  // counter needs at least one bit even for decim_rate 1
  localparam int cnt_w = (decim_rate > 1) ? $clog2(decim_rate) : 1;

  logic [cnt_w-1:0] strobe_cnt;  // strobes since the last kept one
  logic             keep;

  assign keep = sample_strobe && (strobe_cnt == '0);  // strobes 0, R, 2R, ...

  always_ff @(posedge clk) begin
    if (rst) begin
      strobe_cnt <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= keep;  // one cycle after the kept strobe
      if (sample_strobe) begin
        strobe_cnt <= (strobe_cnt == cnt_w'(decim_rate - 1)) ? '0 : strobe_cnt + 1'b1;
      end
    end
  end

  // payload, only moves on a kept strobe
  always_ff @(posedge clk) begin
    if (keep) pair <= sample_in;
  end

endmodule

/* peak_finder.sv */
module peak_finder #(
  parameter int frame_len = 2048
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dsp_pkg::sample_pair_t pair,
  input  logic                  pair_valid,
  output dsp_pkg::peak_t        peak,
  output logic                  peak_valid
);

  import dsp_pkg::*;

  localparam index_t last_pos = index_t'(frame_len - 1);

  logic signed [14:0] ext_a, ext_b;  // one bit wider so -8192 negates cleanly
  logic [14:0]        abs_a, abs_b;
  logic signed [15:0] diff;          // |a| - |b| before halving
  amp_t               amp;

  index_t pos;        // frame position of the incoming value
  amp_t   prev_val;   // value before the current one, 0 at frame start
  amp_t   best;
  amp_t   best_prev;
  amp_t   best_next;
  index_t best_idx;
  logic   need_next;  // last value was a new maximum, next one is its neighbour
  logic   new_max;
  logic   last;
  peak_t  record;     // tracking state including the current value

  if (frame_len > max_frame_len) begin : g_len_check
    $error("peak_finder: frame_len larger than the index type allows");
  end

  // amplitude difference
  always_comb begin
    ext_a = 15'($signed(pair.chan_a));
    ext_b = 15'($signed(pair.chan_b));
    abs_a = ext_a[14] ? -ext_a : ext_a;
    abs_b = ext_b[14] ? -ext_b : ext_b;
    diff  = $signed({1'b0, abs_a}) - $signed({1'b0, abs_b});
    amp   = amp_t'(diff >>> 1);  // arithmetic halve, fits 14 bits
  end

  assign last    = (pos == last_pos);
  assign new_max = (pos == '0) || (amp > best);  // strict, first of a tie stays

  always_comb begin
    record.prev  = best_prev;
    record.peak  = best;
    record.next  = need_next ? amp : best_next;  // capture right after a new max
    record.index = best_idx;
    if (new_max) begin
      record.prev  = prev_val;
      record.peak  = amp;
      record.next  = '0;  // stays 0 if the max is the last value
      record.index = pos;
    end
  end

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      pos        <= '0;
      prev_val   <= '0;
      need_next  <= 1'b0;
      peak_valid <= 1'b0;
    end else begin
      peak_valid <= pair_valid && last;  // one cycle after the last value
      if (pair_valid) begin
        if (last) begin
          pos       <= '0;
          prev_val  <= '0;  // gives prev = 0 for index 0
          need_next <= 1'b0;
        end else begin
          pos       <= pos + 1'b1;
          prev_val  <= amp;
          need_next <= new_max;
        end
      end
    end
  end

  // best-so-far, position 0 always overwrites it
  always_ff @(posedge clk) begin
    if (pair_valid) begin
      best      <= record.peak;
      best_prev <= record.prev;
      best_next <= record.next;
      best_idx  <= record.index;
      if (last) peak <= record;
    end
  end

endmodule

/* energy_root.sv */
module energy_root (
  input  logic            clk,
  input  logic            rst,
  input  dsp_pkg::peak_t  peak,
  input  logic            peak_valid,
  output dsp_pkg::root_t  root,
  output dsp_pkg::index_t index,
  output logic            root_valid
);

  import dsp_pkg::*;

  localparam int steps  = $bits(root_t);      // one result bit per cycle
  localparam int step_w = $clog2(steps);
  localparam int rem_w  = $bits(root_t) + 3;  // remainder plus two shifted-in bits

  typedef enum logic {
    sq_idle,
    sq_run
  } sq_state_t;

  sq_state_t          state;
  logic [step_w-1:0]  step;
  logic signed [27:0] sq_prev, sq_peak, sq_next;
  energy_t            sum;
  energy_t            radicand;   // consumed two bits per step, msbs first
  logic [rem_w-1:0]   rem;
  logic [rem_w-1:0]   rem_shift;
  logic [rem_w-1:0]   trial;      // 4*root + 1
  logic               accept;

  assign accept = (state == sq_idle) && peak_valid;  // busy drops new peaks

  always_comb begin
    sq_prev   = peak.prev * peak.prev;
    sq_peak   = peak.peak * peak.peak;
    sq_next   = peak.next * peak.next;
    sum       = energy_t'(sq_prev) + energy_t'(sq_peak) + energy_t'(sq_next);
    rem_shift = {rem[rem_w-3:0], radicand[$bits(energy_t)-1 -: 2]};
    trial     = rem_w'({root, 2'b01});
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= sq_idle;
      step       <= '0;
      root_valid <= 1'b0;
    end else begin
      root_valid <= 1'b0;
      case (state)
        sq_idle: begin
          step <= '0;
          if (accept) state <= sq_run;
        end
        sq_run: begin
          step <= step + 1'b1;
          if (step == step_w'(steps - 1)) begin
            state      <= sq_idle;
            root_valid <= 1'b1;  // root holds the last bit now
          end
        end
        default: state <= sq_idle;
      endcase
    end
  end

  // restoring square root datapath
  always_ff @(posedge clk) begin
    if (accept) begin
      radicand <= sum;
      rem      <= '0;
      root     <= '0;
      index    <= peak.index;  // rides along to the report
    end else if (state == sq_run) begin
      radicand <= radicand << 2;
      if (rem_shift >= trial) begin
        rem  <= rem_shift - trial;
        root <= {root[$bits(root_t)-2:0], 1'b1};
      end else begin
        rem  <= rem_shift;  // restore
        root <= {root[$bits(root_t)-2:0], 1'b0};
      end
    end
  end

endmodule

/* uart_report_tx.sv */
module uart_report_tx #(
  parameter int clks_per_bit = 868
) (
  input  logic            clk,
  input  logic            rst,
  input  dsp_pkg::root_t  root,
  input  dsp_pkg::index_t index,
  input  logic            root_valid,
  output logic            tx,
  output logic            busy
);

  import link_pkg::*;

  localparam int baud_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
  localparam int bit_w  = $clog2($bits(byte_t));
  localparam int byte_w = $clog2(report_bytes);

  tx_state_t                  state;
  logic [baud_w-1:0]          baud_cnt;  // cycles into the current bit
  logic [bit_w-1:0]           bit_cnt;   // data bit on the line
  logic [byte_w-1:0]          byte_cnt;  // bytes already started
  byte_t [report_bytes-1:0]   report_q;  // top entry is on the line
  byte_t                      cur_byte;
  logic                       bit_end;
  logic                       last_byte;

  assign cur_byte  = report_q[report_bytes-1];
  assign bit_end   = (baud_cnt == baud_w'(clks_per_bit - 1));
  assign last_byte = (byte_cnt == byte_w'(report_bytes - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle;
      tx       <= 1'b1;  // line idles high
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else begin
      baud_cnt <= (state == idle || bit_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        idle: if (root_valid) begin  // while busy a report is dropped
          state    <= start;
          tx       <= 1'b0;
          busy     <= 1'b1;
          byte_cnt <= '0;
        end
        start: if (bit_end) begin
          state   <= data;
          tx      <= cur_byte[0];  // lsb first
          bit_cnt <= '0;
        end
        data: if (bit_end) begin
          if (bit_cnt == bit_w'($bits(byte_t) - 1)) begin
            state <= stop;
            tx    <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            tx      <= cur_byte[bit_cnt + 1'b1];
          end
        end
        stop: if (bit_end) begin
          if (last_byte) begin
            state <= idle;
            busy  <= 1'b0;  // after the last stop bit
          end else begin
            state    <= start;
            tx       <= 1'b0;
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // report bytes, 16 bit fields zero-extended
  always_ff @(posedge clk) begin
    if (state == idle && root_valid) begin
      report_q <= {16'(root), 16'(index)};
    end else if (state == stop && bit_end && !last_byte) begin
      report_q <= {report_q[report_bytes-2:0], byte_t'(0)};  // next byte to the top
    end
  end

endmodule

/* peak_energy_top.sv */
module peak_energy_top #(
  parameter int decim_rate   = 7,
  parameter int frame_len    = 2048,
  parameter int clks_per_bit = 868
) (
  input  logic                  clk,
  input  logic                  rst,
  input  dsp_pkg::sample_pair_t sample_in,
  input  logic                  sample_strobe,
  output logic                  tx
);

  import dsp_pkg::*;

  sample_pair_t pair;
  logic         pair_valid;
  peak_t        peak;
  logic         peak_valid;
  root_t        root;
  index_t       root_index;  // frame index delayed with the root
  logic         root_valid;

  // keep every decim_rate-th strobe
  decimator #(
    .decim_rate (decim_rate)
  ) decimator_i (
    .clk           (clk),
    .rst           (rst),
    .sample_in     (sample_in),
    .sample_strobe (sample_strobe),
    .pair          (pair),
    .pair_valid    (pair_valid)
  );

  // per-frame maximum and neighbours
  peak_finder #(
    .frame_len (frame_len)
  ) peak_finder_i (
    .clk        (clk),
    .rst        (rst),
    .pair       (pair),
    .pair_valid (pair_valid),
    .peak       (peak),
    .peak_valid (peak_valid)
  );

  energy_root energy_root_i (
    .clk        (clk),
    .rst        (rst),
    .peak       (peak),
    .peak_valid (peak_valid),
    .root       (root),
    .index      (root_index),
    .root_valid (root_valid)
  );

  // busy only watched from inside, no back-pressure upstream
  uart_report_tx #(
    .clks_per_bit (clks_per_bit)
  ) uart_report_tx_i (
    .clk        (clk),
    .rst        (rst),
    .root       (root),
    .index      (root_index),
    .root_valid (root_valid),
    .tx         (tx),
    .busy       ()
  );

endmodule

/* peak_energy_assertions.sv */
module peak_energy_assertions (
  input logic clk,
  input logic rst,
  input logic tx,
  input logic busy,
  input logic peak_valid
);

  // uart line idles high
  tx_idle_high: assert property (@(posedge clk) disable iff (rst) !busy |-> tx)
    else $error("tx low while the transmitter is idle");

  // start bit goes out with busy
  tx_start_bit: assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> !tx)
    else $error("no start bit on the first busy cycle");

  peak_one_cycle: assert property (@(posedge clk) disable iff (rst) peak_valid |=> !peak_valid)
    else $error("peak_valid held for two cycles");

endmodule

// transmitter side, no peak strobe here
bind uart_report_tx peak_energy_assertions uart_checks_i (
  .clk        (clk),
  .rst        (rst),
  .tx         (tx),
  .busy       (busy),
  .peak_valid (1'b0)
);

// peak side, line tied idle
bind peak_finder peak_energy_assertions peak_checks_i (
  .clk        (clk),
  .rst        (rst),
  .tx         (1'b1),
  .busy       (1'b0),
  .peak_valid (peak_valid)
);

/* tb_peak_energy.sv */
module tb_peak_energy;

  import dsp_pkg::*;
  import link_pkg::*;

  localparam int decim_rate    = 2;
  localparam int frame_len     = 8;
  localparam int clks_per_bit  = 8;
  localparam int frame_strobes = decim_rate * frame_len;  // 16 strobes per frame
  localparam int idle_cycles   = 2;                       // gap after each strobe
  localparam int start_timeout = 200;                     // cycles to wait for a start bit

  logic         clk;
  logic         rst;
  logic         sample_strobe;
  logic         tx;
  sample_pair_t sample_in;

  int          errors;       // over the whole run
  int          test_errors;  // current test only
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;
  sample_t     frame_a [frame_strobes];  // strobe values of the next frame
  sample_t     frame_b [frame_strobes];

  peak_energy_top #(
    .decim_rate   (decim_rate),
    .frame_len    (frame_len),
    .clks_per_bit (clks_per_bit)
  ) peak_energy_top_i (
    .clk           (clk),
    .rst           (rst),
    .sample_in     (sample_in),
    .sample_strobe (sample_strobe),
    .tx            (tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic sample_t lcg_sample();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return sample_t'(lcg_state[29:16]);  // upper bits spread better
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic fill_frame(input int a, input int b);
    for (int s = 0; s < frame_strobes; s++) begin
      frame_a[s] = sample_t'(a);
      frame_b[s] = sample_t'(b);
    end
  endtask

  // value k of the frame sits on strobe decim_rate*k
  task automatic set_kept(input int k, input int a, input int b);
    frame_a[decim_rate * k] = sample_t'(a);
    frame_b[decim_rate * k] = sample_t'(b);
  endtask

  task automatic drive_strobes(input int count);
    for (int s = 0; s < count; s++) begin
      @(negedge clk);
      sample_in.chan_a = frame_a[s];
      sample_in.chan_b = frame_b[s];
      sample_strobe    = 1'b1;
      @(negedge clk);
      sample_strobe = 1'b0;
      repeat (idle_cycles) @(negedge clk);
    end
  endtask

  task automatic apply_reset(input int cycles);
    @(negedge clk);
    rst = 1'b1;
    repeat (cycles) @(negedge clk);
    rst = 1'b0;
  endtask

  // halved |a| - |b|
  function automatic int amp_of(input sample_t a, input sample_t b);
    int abs_a;
    int abs_b;
    abs_a = a[13] ? -int'(a) : int'(a);
    abs_b = b[13] ? -int'(b) : int'(b);
    return (abs_a - abs_b) >>> 1;  // rounds toward minus infinity
  endfunction

  // reference model of one frame report
  task automatic expect_report(output logic [31:0] exp_root, output logic [31:0] exp_index);
    int     vals [frame_len];
    int     best_k;
    int     prev_v;
    int     next_v;
    longint energy;
    longint r;
    for (int k = 0; k < frame_len; k++) begin
      vals[k] = amp_of(frame_a[decim_rate * k], frame_b[decim_rate * k]);
    end
    best_k = 0;
    for (int k = 1; k < frame_len; k++) begin
      if (vals[k] > vals[best_k]) best_k = k;  // first maximum wins
    end
    prev_v = (best_k == 0) ? 0 : vals[best_k - 1];
    next_v = (best_k == frame_len - 1) ? 0 : vals[best_k + 1];
    energy = longint'(prev_v) * longint'(prev_v) + longint'(vals[best_k]) *
             longint'(vals[best_k]) + longint'(next_v) * longint'(next_v);
    r = 0;
    while ((r + 1) * (r + 1) <= energy) r++;  // plain floor sqrt search
    exp_root  = 32'(r);
    exp_index = 32'(best_k);
  endtask

  // four 8n1 bytes sampled mid-bit on falling edges
  task automatic receive_report(input string name, output logic [31:0] got_root,
                                output logic [31:0] got_index);
    byte_t rx [report_bytes];
    int    waited;
    got_root  = '1;
    got_index = '1;
    for (int n = 0; n < report_bytes; n++) begin
      waited = 0;
      while (tx !== 1'b0 && waited < start_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (tx !== 1'b0) begin
        $display("%s: no start bit for byte %0d within %0d cycles", name, n, start_timeout);
        test_errors++;
        return;
      end
      repeat (clks_per_bit / 2 - 1) @(negedge clk);  // middle of the start bit
      if (tx !== 1'b0) begin
        $display("%s: start bit of byte %0d did not last", name, n);
        test_errors++;
      end
      for (int b = 0; b < $bits(byte_t); b++) begin
        repeat (clks_per_bit) @(negedge clk);
        rx[n][b] = tx;  // lsb first
      end
      repeat (clks_per_bit) @(negedge clk);
      if (tx !== 1'b1) begin
        $display("%s: stop bit of byte %0d is low", name, n);
        test_errors++;
      end
    end
    got_root  = {16'h0, rx[0], rx[1]};
    got_index = {16'h0, rx[2], rx[3]};
  endtask

  // tx has to stay high for the given number of cycles
  task automatic expect_quiet(input string name, input int cycles);
    int waited;
    waited = 0;
    while (tx === 1'b1 && waited < cycles) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b1) begin
      $display("%s: tx left idle after %0d cycles when no report was due", name, waited);
      test_errors++;
    end
  endtask

  task automatic run_frame(input string name);
    logic [31:0] exp_root;
    logic [31:0] exp_index;
    logic [31:0] got_root;
    logic [31:0] got_index;
    expect_report(exp_root, exp_index);
    drive_strobes(frame_strobes);
    receive_report(name, got_root, got_index);
    check_value({name, " root"}, exp_root, got_root);
    check_value({name, " index"}, exp_index, got_index);
    expect_quiet(name, 2 * clks_per_bit);  // line back to idle
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %s finished with %0d errors", name, test_errors);
    errors      += test_errors;
    test_errors  = 0;
  endtask

  task automatic test_decimation();
    fill_frame(8191, 0);  // odd strobes would dominate if kept
    for (int k = 0; k < frame_len; k++) set_kept(k, 20 * k, -5);
    set_kept(5, 1500, 0);
    run_frame("decimation");
    finish_test("decimation");
  endtask

  task automatic test_random_peak();
    for (int s = 0; s < frame_strobes; s++) begin
      frame_a[s] = lcg_sample();
      frame_b[s] = lcg_sample();
    end
    set_kept(4, -8192, 0);  // most negative sample has the largest magnitude
    run_frame("random_peak");
    finish_test("random_peak");
  endtask

  task automatic test_edge_peaks();
    fill_frame(200, -100);
    set_kept(0, 4000, 0);
    run_frame("edge_first");
    fill_frame(200, -100);
    set_kept(frame_len - 1, -4000, 0);
    run_frame("edge_last");
    finish_test("edge_peaks");
  endtask

  task automatic test_ties_sign();
    fill_frame(-10, 2000);  // channel b wins everywhere
    set_kept(2, -10, 500);
    set_kept(5, 10, -500);  // same amplitude as index 2
    set_kept(6, 0, 900);
    run_frame("ties_sign");
    finish_test("ties_sign");
  endtask

  task automatic test_reset_mid_frame();
    fill_frame(100, 0);
    set_kept(1, 7000, 0);
    drive_strobes(7);  // part of a frame only
    apply_reset(4);
    drive_strobes(frame_strobes / 2);  // would finish the old frame if its state survived
    expect_quiet("reset_mid_frame", 100);
    apply_reset(4);  // drop the second partial frame too
    fill_frame(50, 0);
    set_kept(6, 3000, 0);  // index counted from the restart
    run_frame("reset_mid_frame");
    finish_test("reset_mid_frame");
  endtask

  initial begin
    rst           = 1'b1;
    sample_strobe = 1'b0;
    sample_in     = '0;
    lcg_state     = 32'h91ae_3ed9;
    errors        = 0;
    test_errors   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    test_decimation();
    test_random_peak();
    test_edge_peaks();
    test_ties_sign();
    test_reset_mid_frame();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
dsp_pkg.sv
link_pkg.sv
decimator.sv
peak_finder.sv
energy_root.sv
uart_report_tx.sv
peak_energy_top.sv
peak_energy_assertions.sv
tb_peak_energy.sv

/* run_sim.sh */
#!/bin/sh

log=sim.log

verilator --binary --assert --top-module tb_peak_energy -f vlog.f -o sim_peak_energy
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_peak_energy > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  exit 1
fi
if ! grep -q "sim passed" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
